/* src/tl_pkg.sv */
package tl_pkg;

	localparam int data_w = 32;
	localparam int mask_w = data_w / 8;
	localparam int addr_w = 32;
	localparam int source_w = 4;
	localparam int size_w = 4;

	localparam int beat_bytes = 4;
	localparam int byte_off_w = $clog2(beat_bytes);

	// Largest legal transfers, as log2 of bytes
	localparam int max_get_size = 4;
	localparam int max_put_size = byte_off_w;

	// log2 of the beat count of the longest encodable burst
	localparam int beat_cnt_w = 2 ** size_w - 1 - byte_off_w;

	localparam logic [addr_w-1:0] dtim_base = 32'h8000_0000;
	localparam int dtim_words = 256;
	localparam int dtim_idx_w = $clog2(dtim_words);

	typedef enum logic [2:0] {
		put_full = 3'd0,
		put_partial = 3'd1,
		arithmetic = 3'd2,
		logical = 3'd3,
		get = 3'd4,
		intent = 3'd5
	} a_opcode_e;

	typedef enum logic [2:0] {
		access_ack = 3'd0,
		access_ack_data = 3'd1
	} d_opcode_e;

	typedef struct packed {
		logic [addr_w-1:0] base;
		logic [addr_w-1:0] limit; // Exclusive
		logic r;
		logic w;
	} region_t;

	localparam int num_regions = 7;
	localparam int dtim_region = 6;

	localparam region_t region_table [num_regions] = '{
		'{32'h0000_0000, 32'h0000_1000, 1'b1, 1'b1}, // debug
		'{32'h0000_3000, 32'h0000_4000, 1'b1, 1'b1}, // error device
		'{32'h0001_0000, 32'h0002_0000, 1'b1, 1'b0}, // rom
		'{32'h0200_0000, 32'h0201_0000, 1'b1, 1'b1}, // clint
		'{32'h0c00_0000, 32'h1000_0000, 1'b1, 1'b1}, // plic
		'{32'h6000_0000, 32'h8000_0000, 1'b1, 1'b1}, // mmio
		'{dtim_base, dtim_base + dtim_words * beat_bytes, 1'b1, 1'b1}
	};

	typedef struct packed {
		a_opcode_e opcode;
		logic [size_w-1:0] size;
		logic [source_w-1:0] source;
		logic [addr_w-1:0] address;
		logic [mask_w-1:0] mask;
		logic [data_w-1:0] data;
	} tl_a_req_t;

	typedef struct packed {
		d_opcode_e opcode;
		logic [size_w-1:0] size;
		logic [source_w-1:0] source;
		logic [data_w-1:0] data;
		logic error;
	} tl_d_beat_t;

endpackage

/* src/tl_skid.sv */
module tl_skid #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,

	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);
	logic main_valid, skid_valid;
	logic main_valid_n, skid_valid_n;
	logic in_fire, main_load;
	payload_t main_data, skid_data;

	assign in_fire = in_valid && in_ready;
	assign main_load = !main_valid || out_ready; // Main empty or draining now

	always_comb begin
		main_valid_n = main_valid;
		skid_valid_n = skid_valid;
		if (main_load) begin
			main_valid_n = skid_valid || in_fire;
			skid_valid_n = 1'b0;
		end else if (in_fire) begin
			skid_valid_n = 1'b1; // Main stalled, park the new item
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
			in_ready <= 1'b0;
		end else begin
			main_valid <= main_valid_n;
			skid_valid <= skid_valid_n;
			in_ready <= !skid_valid_n;
		end
	end

	always_ff @(posedge clock) begin
		if (main_load)
			main_data <= skid_valid ? skid_data : in_data;
		if (in_fire)
			skid_data <= in_data;
	end

	assign out_valid = main_valid;
	assign out_data = main_data;

endmodule

/* src/pma_check.sv */
module pma_check (
	input logic [tl_pkg::addr_w-1:0] address,
	input logic [tl_pkg::size_w-1:0] size,
	input tl_pkg::a_opcode_e opcode,
	output logic permitted,
	output logic in_dtim
);
	import tl_pkg::*;

	logic [addr_w-1:0] size_mask;
	logic [addr_w-1:0] first_byte, last_byte;
	int first_region, last_region;
	logic same_region;
	logic can_read, can_write;
	logic aligned, is_put;

	// Index of the region holding addr, num_regions when unmapped
	function automatic int region_of(input logic [addr_w-1:0] addr);
		int hit;
		hit = num_regions;
		for (int i = 0; i < num_regions; i++) begin
			if (addr >= region_table[i].base && addr < region_table[i].limit)
				hit = i;
		end
		return hit;
	endfunction

	assign size_mask = (addr_w'(1) << size) - 1'b1;
	assign first_byte = address;
	assign last_byte = address + size_mask;

	assign first_region = region_of(first_byte);
	assign last_region = region_of(last_byte);

	// Both ends must land in one region
	assign same_region = first_region == last_region && first_region < num_regions;

	always_comb begin
		can_read = 1'b0;
		can_write = 1'b0;
		if (same_region) begin
			can_read = region_table[first_region].r;
			can_write = region_table[first_region].w;
		end
	end

	assign aligned = (address & size_mask) == '0;
	assign is_put = opcode == put_full || opcode == put_partial;

	always_comb begin
		permitted = 1'b0;
		if (aligned && size <= max_get_size) begin
			if (opcode == get)
				permitted = can_read;
			else if (is_put)
				permitted = can_write && size <= max_put_size; // No multi-beat puts
		end
	end

	assign in_dtim = same_region && first_region == dtim_region;

endmodule

/* src/tl_mem_engine.sv */
module tl_mem_engine (
	input logic clock,
	input logic reset,

	input logic req_valid,
	output logic req_ready,
	input tl_pkg::tl_a_req_t req,

	output logic [tl_pkg::addr_w-1:0] pma_address,
	output logic [tl_pkg::size_w-1:0] pma_size,
	output tl_pkg::a_opcode_e pma_opcode,
	input logic permitted,
	input logic in_dtim,

	output logic beat_valid,
	input logic beat_ready,
	output tl_pkg::tl_d_beat_t beat
);
	import tl_pkg::*;

	logic busy;
	a_opcode_e op_opcode;
	logic [size_w-1:0] op_size;
	logic [source_w-1:0] op_source;
	logic op_permitted, op_dtim;
	logic [beat_cnt_w-1:0] beat_cnt, op_beats_m1, req_beats_m1;
	logic [dtim_idx_w-1:0] word_idx, rd_idx;
	logic [data_w-1:0] rd_data;
	logic [data_w-1:0] ram [dtim_words];
	logic accept, beat_fire, last_beat, next_read, req_is_put;

	// Checker looks at the request waiting at our input
	assign pma_address = req.address;
	assign pma_size = req.size;
	assign pma_opcode = req.opcode;

	assign beat_valid = busy;
	assign beat_fire = beat_valid && beat_ready;
	assign last_beat = beat_cnt == op_beats_m1;
	assign req_ready = !busy || (beat_fire && last_beat);
	assign accept = req_valid && req_ready;
	assign next_read = beat_fire && !last_beat;
	assign req_is_put = req.opcode == put_full || req.opcode == put_partial;

	// One beat per word of a Get, a single beat otherwise
	always_comb begin
		req_beats_m1 = '0;
		if (req.opcode == get && req.size > byte_off_w)
			req_beats_m1 = beat_cnt_w'((1 << (req.size - byte_off_w)) - 1);
	end

	assign rd_idx = accept ? req.address[byte_off_w +: dtim_idx_w] : word_idx + 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			beat_cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			beat_cnt <= '0;
		end else if (beat_fire) begin
			if (last_beat)
				busy <= 1'b0;
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_opcode <= req.opcode;
			op_size <= req.size;
			op_source <= req.source;
			op_permitted <= permitted;
			op_dtim <= in_dtim;
			op_beats_m1 <= req_beats_m1;
		end
		if (accept || next_read)
			word_idx <= rd_idx;
	end

	// dtim RAM, byte-masked write on acceptance
	always_ff @(posedge clock) begin
		if (accept && req_is_put && permitted && in_dtim) begin
			for (int b = 0; b < mask_w; b++) begin
				if (req.mask[b])
					ram[rd_idx][b*8 +: 8] <= req.data[b*8 +: 8];
			end
		end
		if (accept || next_read)
			rd_data <= ram[rd_idx]; // Registered read feeds the next beat
	end

	always_comb begin
		beat = '0;
		beat.size = op_size;
		beat.source = op_source;
		beat.error = !op_permitted; // UH opcodes never pass the checker
		if (op_opcode == get) begin
			beat.opcode = access_ack_data;
			if (op_permitted && op_dtim)
				beat.data = rd_data;
		end else begin
			beat.opcode = access_ack;
		end
	end

endmodule

/* src/tl_mem_slave.sv */
module tl_mem_slave (
	input logic clock,
	input logic reset,

	input logic a_valid,
	output logic a_ready,
	input tl_pkg::tl_a_req_t a_bits,

	output logic d_valid,
	input logic d_ready,
	output tl_pkg::tl_d_beat_t d_bits
);
	import tl_pkg::*;

	logic req_valid, req_ready;
	tl_a_req_t req;
	logic [addr_w-1:0] pma_address;
	logic [size_w-1:0] pma_size;
	a_opcode_e pma_opcode;
	logic permitted, in_dtim;
	logic beat_valid, beat_ready;
	tl_d_beat_t beat;

	tl_skid #(.payload_t(tl_a_req_t)) u_a_skid (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (a_valid),
		.in_ready  (a_ready),
		.in_data   (a_bits),
		.out_valid (req_valid),
		.out_ready (req_ready),
		.out_data  (req)
	);

	pma_check u_pma (
		.address   (pma_address),
		.size      (pma_size),
		.opcode    (pma_opcode),
		.permitted (permitted),
		.in_dtim   (in_dtim)
	);

	tl_mem_engine u_engine (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req         (req),
		.pma_address (pma_address),
		.pma_size    (pma_size),
		.pma_opcode  (pma_opcode),
		.permitted   (permitted),
		.in_dtim     (in_dtim),
		.beat_valid  (beat_valid),
		.beat_ready  (beat_ready),
		.beat        (beat)
	);

	tl_skid #(.payload_t(tl_d_beat_t)) u_d_skid (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (beat_valid),
		.in_ready  (beat_ready),
		.in_data   (beat),
		.out_valid (d_valid),
		.out_ready (d_ready),
		.out_data  (d_bits)
	);

endmodule

/* tb/tl_ref_model.svh */
// Memory map regions, index 6 is the dtim
localparam int model_regions = 7;
localparam int model_dtim = 6;
localparam logic [31:0] model_base [model_regions] = '{32'h0000_0000, 32'h0000_3000,
	32'h0001_0000, 32'h0200_0000, 32'h0c00_0000, 32'h6000_0000, 32'h8000_0000};
localparam logic [31:0] model_limit [model_regions] = '{32'h0000_1000, 32'h0000_4000,
	32'h0002_0000, 32'h0201_0000, 32'h1000_0000, 32'h8000_0000, 32'h8000_0400};
localparam logic [model_regions-1:0] model_writable = 7'b111_1011; // rom is read only

logic [31:0] shadow [256];
tl_d_beat_t expected_q [$];
int expected_id_q [$];

function automatic int model_region(input logic [31:0] addr);
	for (int i = 0; i < model_regions; i++)
		if (addr >= model_base[i] && addr < model_limit[i])
			return i;
	return model_regions;
endfunction

function automatic bit access_allowed(input tl_a_req_t req);
	logic [31:0] span;
	int region;
	span = (32'd1 << req.size) - 32'd1;
	region = model_region(req.address);
	if (region == model_regions || region != model_region(req.address + span))
		return 1'b0; // Unmapped or crossing
	if ((req.address & span) != 32'd0 || req.size > 4'd4)
		return 1'b0;
	if (req.opcode == get)
		return 1'b1;
	return (req.opcode == put_full || req.opcode == put_partial)
		&& model_writable[region] && req.size <= 4'd2;
endfunction

// Expected D beats of one accepted request, and its effect on the dtim
task automatic push_expected(input tl_a_req_t req, input int id);
	tl_d_beat_t beat;
	bit allowed, dtim;
	int beats;
	allowed = access_allowed(req);
	dtim = model_region(req.address) == model_dtim;
	beats = (req.opcode == get && req.size > 4'd2) ? 1 << (req.size - 4'd2) : 1;
	if (allowed && dtim && req.opcode != get)
		for (int b = 0; b < 4; b++)
			if (req.mask[b])
				shadow[req.address[9:2]][b*8 +: 8] = req.data[b*8 +: 8];
	beat = '0;
	beat.opcode = req.opcode == get ? access_ack_data : access_ack;
	beat.size = req.size;
	beat.source = req.source;
	beat.error = !allowed;
	for (int n = 0; n < beats; n++) begin
		if (req.opcode == get && allowed && dtim)
			beat.data = shadow[req.address[9:2] + 8'(n)];
		expected_q.push_back(beat);
		expected_id_q.push_back(id);
	end
endtask

/* tb/tb_tl_mem_slave.sv */
module tb_tl_mem_slave;
	timeunit 1ns;
	timeprecision 1ps;
	import tl_pkg::*;

	localparam int random_requests = 300;
	localparam int wait_limit = 1000;

	logic clock = 1'b0;
	logic reset, a_valid, a_ready, d_valid;
	logic d_ready = 1'b0;
	tl_a_req_t a_bits;
	tl_d_beat_t d_bits;
	logic [31:0] stim_state = 32'd84955;
	logic [31:0] ready_state = 32'd84955;
	int errors = 0;
	int protocol_errors = 0;
	int timeouts = 0;
	int sent = 0;

	`include "tl_ref_model.svh"

	tl_mem_slave u_tl_mem_slave (.*);

	always #10 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
	endfunction

	function automatic logic [31:0] stim_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], stim_state[0]};
			stim_state = lfsr_next(stim_state);
		end
		return value;
	endfunction

	function automatic tl_a_req_t random_request();
		tl_a_req_t req;
		logic [3:0] pick, kind;
		logic [31:0] offset;
		pick = 4'(stim_bits(4));
		if (pick < 4'd6) req.opcode = get;
		else if (pick < 4'd10) req.opcode = put_full;
		else if (pick < 4'd13) req.opcode = put_partial;
		else if (pick == 4'd13) req.opcode = arithmetic;
		else if (pick == 4'd14) req.opcode = logical;
		else req.opcode = intent;
		req.size = 4'(stim_bits(3) % 5);
		if (req.opcode != get && stim_bits(2) != 0)
			req.size = 4'(stim_bits(2) % 3); // Mostly legal put sizes
		req.source = 4'(stim_bits(4));
		req.mask = 4'(stim_bits(4));
		req.data = stim_bits(32);
		offset = stim_bits(12) & ~((32'd1 << req.size) - 32'd1);
		kind = 4'(stim_bits(4));
		case (kind)
			4'd10: req.address = 32'h0001_0000 + offset; // rom
			4'd11: req.address = 32'h6000_0000 + offset;
			4'd12: req.address = offset; // debug
			4'd13: req.address = 32'h4000_0000 + offset; // Unmapped
			4'd14: req.address = 32'h8000_0000 + stim_bits(10);
			4'd15: begin
				req.address = 32'h8000_03fc; // Runs past the dtim end
				req.size = 4'd3 + 4'(stim_bits(1));
			end
			default: req.address = 32'h8000_0000 + (offset & 32'h3ff);
		endcase
		return req;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic send_request(input tl_a_req_t req);
		int cycles;
		cycles = 0;
		a_valid <= 1'b1;
		a_bits <= req;
		@(negedge clock);
		while (a_ready !== 1'b1 && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (a_ready !== 1'b1) begin
			timeouts++;
			$display("Timeout: request %0d was never accepted", sent);
		end else begin
			@(posedge clock); // Transfer edge
			push_expected(req, sent);
			sent++;
		end
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0 && cycles < wait_limit) begin
			@(posedge clock);
			cycles++;
		end
		if (expected_q.size() != 0) begin
			timeouts++;
			$display("Timeout: %0d expected D beats never arrived", expected_q.size());
		end
		repeat (5) @(posedge clock); // Room for stray beats
	endtask

	always @(posedge clock) begin
		d_ready <= !reset && ready_state[0];
		ready_state <= lfsr_next(ready_state);
	end

	// D channel monitor
	initial begin
		tl_d_beat_t want;
		int id;
		forever begin
			@(negedge clock);
			if (reset) begin
				if (d_valid !== 1'b0 || a_ready !== 1'b0) begin
					protocol_errors++;
					$display("a_ready or d_valid is not low during reset");
				end
			end else if (d_valid && d_ready) begin
				if (expected_q.size() == 0) begin
					protocol_errors++;
					$display("D beat arrived with no response outstanding");
				end else begin
					want = expected_q.pop_front();
					id = expected_id_q.pop_front();
					check_value($sformatf("req %0d opcode", id), 32'(want.opcode),
						32'(d_bits.opcode));
					check_value($sformatf("req %0d size", id), 32'(want.size), 32'(d_bits.size));
					check_value($sformatf("req %0d source", id), 32'(want.source),
						32'(d_bits.source));
					check_value($sformatf("req %0d data", id), want.data, d_bits.data);
					check_value($sformatf("req %0d error", id), 32'(want.error),
						32'(d_bits.error));
				end
			end
		end
	end

	initial begin
		tl_a_req_t req;
		reset = 1'b1;
		a_valid = 1'b0;
		a_bits = '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		// Known contents in every dtim word
		for (int i = 0; i < dtim_words && timeouts == 0; i++) begin
			req = '0;
			req.opcode = put_full;
			req.size = 4'd2;
			req.mask = 4'hf;
			req.address = 32'h8000_0000 + 32'(i * 4);
			req.data = req.address ^ {req.address[15:0], req.address[31:16]} ^ 32'h5a5a_a5a5;
			send_request(req);
		end
		for (int n = 0; n < random_requests && timeouts == 0; n++) begin
			send_request(random_request());
			if (stim_bits(2) == 0) begin
				a_valid <= 1'b0;
				@(posedge clock);
			end
		end
		a_valid <= 1'b0;
		wait_for_drain();
		$display("Errors: %0d mismatches, %0d protocol, %0d timeouts",
			errors, protocol_errors, timeouts);
		if (errors == 0 && protocol_errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* Makefile */
TOOL ?= verilator
FLAGS ?= --binary -Wno-fatal -j 0
TOP ?= tb_tl_mem_slave
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
+incdir+tb
src/tl_pkg.sv
src/tl_skid.sv
src/pma_check.sv
src/tl_mem_engine.sv
src/tl_mem_slave.sv
tb/tb_tl_mem_slave.sv
